//--- filelist.f
+incdir+rtl
rtl/keyStreamPkg.sv
rtl/keyStore.sv
rtl/cipherLane.sv
rtl/keyStreamCtrl.sv
rtl/streamOutStage.sv
rtl/keyStreamTop.sv
tests/keyStreamTb_props.sv
tests/keyStreamTb.sv

//--- rtl/cipherLane.sv
// One iterative mixing core, one round per cycle
// Loads a block and key, runs KS_ROUNDS rounds, holds the result until released
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module cipherLane
    import keyStreamPkg::*;
(
    input  logic  Clock,
    input  logic  rst,
    input  logic  load,
    input  keyT   curKey,
    input  blockT plainIn,
    input  logic  relPulse,
    output logic  done,
    output blockT result
);

    localparam int RndW = $clog2(`KS_ROUNDS + 1);

    logic            busy;
    logic            doneReg;
    logic [RndW-1:0] rndCnt;
    blockT           state;
    keyT             laneKey;

    // ----------------------------------------
    // Round function
    // ----------------------------------------
    function automatic blockT mixRound(input blockT s, input keyT k, input logic [31:0] rnd);
        blockT t;
        t = s ^ k;
        // Whole-state rotate left by 5
        t = {t[122:0], t[127:123]};
        // Round number into the low word, mod 2^32
        t[31:0] = t[31:0] + rnd;
        return t;
    endfunction

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (rst) begin
            busy    <= 1'b0;
            doneReg <= 1'b0;
            rndCnt  <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            doneReg <= 1'b0;
            rndCnt  <= '0;
        end else if (busy) begin
            rndCnt <= rndCnt + 1'b1;
            // Last round lands on this edge
            if (rndCnt == RndW'(`KS_ROUNDS - 1)) begin
                busy    <= 1'b0;
                doneReg <= 1'b1;
            end
        end else if (relPulse) begin
            doneReg <= 1'b0;
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge Clock) begin
        if (load) begin
            state   <= plainIn;
            laneKey <= curKey;
        end else if (busy) begin
            // Rounds count from 1
            state <= mixRound(state, laneKey, 32'(rndCnt) + 32'd1);
        end
    end

    assign done   = doneReg;
    assign result = state;

endmodule

//--- rtl/keyStore.sv
// Holds the cipher key shared by all lanes
// Accepts a new key only while the slot array is idle
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module keyStore
    import keyStreamPkg::*;
(
    input  logic Clock,
    input  logic rst,
    input  keyT  key,
    input  logic keyValid,
    output logic keyReady,
    input  logic pipeIdle,
    output keyT  curKey,
    output logic keyLoaded
);

    keyStateT keyState;
    keyT      keyReg;
    logic     keyFire;

    // Slots capture the key at load, but a swap is still held off until idle
    assign keyReady = pipeIdle;
    assign keyFire  = keyValid && keyReady;

    // Load FSM
    always_ff @(posedge Clock) begin
        if (rst) begin
            keyState <= keyEmpty;
        end else begin
            case (keyState)
                keyEmpty: if (keyFire) keyState <= keyStreamPkg::keyLoaded;
                // Stays loaded, later keys just overwrite the register
                default: keyState <= keyStreamPkg::keyLoaded;
            endcase
        end
    end

    // Key payload
    always_ff @(posedge Clock) begin
        if (keyFire) begin
            keyReg <= key;
        end
    end

    assign curKey    = keyReg;
    assign keyLoaded = (keyState == keyStreamPkg::keyLoaded);

endmodule

//--- rtl/keyStreamCtrl.sv
// Slot control for the keystream generator
// Allocates slots in turn, releases them in order against output credits
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module keyStreamCtrl
    import keyStreamPkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 seedValid,
    output logic                 seedReady,
    input  logic                 keyLoaded,
    input  logic [`KS_SLOTS-1:0] slotDone,
    input  logic                 creditReturn,
    output logic [`KS_SLOTS-1:0] loadStrobe,
    output releaseT              rel,
    output logic                 pipeIdle
);

    slotIdxT inTurn;
    slotIdxT outTurn;
    occT     occ;
    occT     occNext;
    creditT  credits;
    logic    idleReg;
    logic    seedFire;
    logic    relFire;

    // Pointer step, wraps at KS_SLOTS
    function automatic slotIdxT nextSlot(input slotIdxT p);
        slotIdxT n;
        if (p == slotIdxT'(`KS_SLOTS - 1)) begin
            n = '0;
        end else begin
            n = p + 1'b1;
        end
        return n;
    endfunction

    // ----------------------------------------
    // Seed side
    // ----------------------------------------
    // Needs a key and a free slot
    assign seedReady = keyLoaded && (occ < occT'(`KS_SLOTS));
    assign seedFire  = seedValid && seedReady;

    // One-hot load of the in-turn slot
    always_comb begin
        loadStrobe = '0;
        if (seedFire) begin
            loadStrobe[inTurn] = 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            inTurn <= '0;
        end else if (seedFire) begin
            inTurn <= nextSlot(inTurn);
        end
    end

    // ----------------------------------------
    // Release side
    // ----------------------------------------
    // Oldest slot goes out once all its lanes finish and a credit is held
    assign relFire   = slotDone[outTurn] && (credits != '0);
    assign rel.fire  = relFire;
    assign rel.slot  = outTurn;

    always_ff @(posedge Clock) begin
        if (rst) begin
            outTurn <= '0;
        end else if (relFire) begin
            outTurn <= nextSlot(outTurn);
        end
    end

    // Credit count, return and spend may coincide
    always_ff @(posedge Clock) begin
        if (rst) begin
            credits <= creditT'(`KS_OUT_CREDITS);
        end else begin
            case ({creditReturn, relFire})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    always_comb begin
        occNext = occ;
        if (seedFire && !relFire) begin
            occNext = occ + 1'b1;
        end else if (!seedFire && relFire) begin
            occNext = occ - 1'b1;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            occ <= '0;
        end else begin
            occ <= occNext;
        end
    end

    // Idle flag, registered so it stays low during reset
    always_ff @(posedge Clock) begin
        if (rst) begin
            idleReg <= 1'b0;
        end else begin
            idleReg <= (occNext == '0);
        end
    end

    assign pipeIdle = idleReg;

endmodule

//--- rtl/keyStreamPkg.sv
// Types shared by the keystream generator modules
// Pull in with a wildcard import in the module header
`include "keyStream_cfg.svh"

package keyStreamPkg;

    // Data widths
    typedef logic [127:0] blockT;
    typedef logic [127:0] keyT;
    typedef logic [63:0] seedT;
    typedef logic [31:0] seqT;

    // Slot bookkeeping
    typedef logic [$clog2(`KS_SLOTS)-1:0] slotIdxT;
    typedef logic [$clog2(`KS_SLOTS+1)-1:0] occT;
    typedef logic [$clog2(`KS_OUT_CREDITS+1)-1:0] creditT;

    // Key register state
    typedef enum logic {keyEmpty, keyLoaded} keyStateT;

    // One output word, lane 0 in the low block
    typedef struct packed {
        blockT [`KS_LANES-1:0] blocks;
        seqT seq;
    } streamWordT;

    // Slot release from control to the output stage
    typedef struct packed {
        logic fire;
        slotIdxT slot;
    } releaseT;

endpackage

//--- rtl/keyStreamTop.sv
// Counter-mode keystream generator top level
// Seed and key in by valid/ready, words out against consumer credits
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module keyStreamTop
    import keyStreamPkg::*;
(
    input  logic       Clock,
    input  logic       rst,
    input  seedT       seed,
    input  logic       seedValid,
    output logic       seedReady,
    input  keyT        key,
    input  logic       keyValid,
    output logic       keyReady,
    output streamWordT streamWord,
    output logic       streamValid,
    input  logic       creditReturn
);

    keyT                  curKey;
    logic                 keyLoaded;
    logic                 pipeIdle;
    logic [`KS_SLOTS-1:0] loadStrobe;
    logic [`KS_SLOTS-1:0] slotDone;
    releaseT              rel;
    blockT [`KS_SLOTS-1:0][`KS_LANES-1:0] laneResults;

    keyStore keyStore_i (
        .Clock     (Clock),
        .rst       (rst),
        .key       (key),
        .keyValid  (keyValid),
        .keyReady  (keyReady),
        .pipeIdle  (pipeIdle),
        .curKey    (curKey),
        .keyLoaded (keyLoaded)
    );

    keyStreamCtrl keyStreamCtrl_i (
        .Clock        (Clock),
        .rst          (rst),
        .seedValid    (seedValid),
        .seedReady    (seedReady),
        .keyLoaded    (keyLoaded),
        .slotDone     (slotDone),
        .creditReturn (creditReturn),
        .loadStrobe   (loadStrobe),
        .rel          (rel),
        .pipeIdle     (pipeIdle)
    );

    // ----------------------------------------
    // Lane array, KS_SLOTS by KS_LANES
    // ----------------------------------------
    for (genvar k = 0; k < `KS_SLOTS; k++) begin : slotGen
        logic [`KS_LANES-1:0] laneDone;
        logic                 slotRel;

        assign slotRel     = rel.fire && (rel.slot == slotIdxT'(k));
        // Slot is done when every lane is
        assign slotDone[k] = &laneDone;

        for (genvar j = 0; j < `KS_LANES; j++) begin : laneGen
            // Counter for lane j is seed + j
            seedT laneSeed;
            assign laneSeed = seed + seedT'(j);

            cipherLane cipherLane_i (
                .Clock    (Clock),
                .rst      (rst),
                .load     (loadStrobe[k]),
                .curKey   (curKey),
                .plainIn  ({{($bits(blockT) - $bits(seedT)){1'b0}}, laneSeed}),
                .relPulse (slotRel),
                .done     (laneDone[j]),
                .result   (laneResults[k][j])
            );
        end
    end

    streamOutStage streamOutStage_i (
        .Clock       (Clock),
        .rst         (rst),
        .rel         (rel),
        .laneResults (laneResults),
        .streamWord  (streamWord),
        .streamValid (streamValid)
    );

endmodule

//--- rtl/keyStream_cfg.svh
// Sizing macros for the keystream generator
// Include in any file that needs lane, slot, round or credit counts
`ifndef KEYSTREAM_CFG_SVH
`define KEYSTREAM_CFG_SVH

// Cipher blocks per keystream word
`define KS_LANES 4

// Slots in flight, one seed each
`define KS_SLOTS 12

// Mixing rounds per block
// This is also the lane latency in cycles
`define KS_ROUNDS 12

// Credits held for the output side after reset
`define KS_OUT_CREDITS 2

`endif

//--- rtl/streamOutStage.sv
// Output register for released keystream words
// Picks the released slot's lane results and tags them with a sequence number
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module streamOutStage
    import keyStreamPkg::*;
(
    input  logic       Clock,
    input  logic       rst,
    input  releaseT    rel,
    input  blockT [`KS_SLOTS-1:0][`KS_LANES-1:0] laneResults,
    output streamWordT streamWord,
    output logic       streamValid
);

    streamWordT wordReg;
    logic       validReg;
    seqT        seqCnt;

    // Word payload, loaded on the release edge
    always_ff @(posedge Clock) begin
        if (rel.fire) begin
            wordReg.blocks <= laneResults[rel.slot];
            wordReg.seq    <= seqCnt;
        end
    end

    // Running tag, first word gets 0
    always_ff @(posedge Clock) begin
        if (rst) begin
            seqCnt <= '0;
        end else if (rel.fire) begin
            seqCnt <= seqCnt + 1'b1;
        end
    end

    // One valid cycle per release
    always_ff @(posedge Clock) begin
        if (rst) begin
            validReg <= 1'b0;
        end else begin
            validReg <= rel.fire;
        end
    end

    assign streamWord  = wordReg;
    assign streamValid = validReg;

endmodule

//--- tests/keyStreamTb.sv
// Testbench for keyStreamTop with a reference model and a credit consumer
// Runs five directed tests, reports one line each, then the totals
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module keyStreamTb
    import keyStreamPkg::*;
();

    // Seeds over all tests, sizes the watchdog
    localparam int SeedsTotal = 1 + (`KS_SLOTS + 4) + 6 + 8;
    localparam int LimitNs    = (SeedsTotal * (`KS_ROUNDS + 10) + 300) * 10;

    logic       Clock;
    logic       rst;
    seedT       seed;
    logic       seedValid;
    logic       seedReady;
    keyT        key;
    logic       keyValid;
    logic       keyReady;
    streamWordT streamWord;
    logic       streamValid;
    logic       creditReturn;

    // Model state
    streamWordT expQ[$];
    int         acceptQ[$];
    int         dueQ[$];
    keyT        modelKey;
    seqT        refSeq;
    seqT        lastSeq;
    integer     seedVar;
    int         cycleCnt;
    int         wordsSeen;
    int         errCnt;
    int         errAtStart;
    int         passTests;
    int         failTests;
    bit         holdCredits;
    bit         checkLatency;
    bit         sawFull;
    string      curTest;

    keyStreamTop keyStreamTop_i (
        .Clock        (Clock),
        .rst          (rst),
        .seed         (seed),
        .seedValid    (seedValid),
        .seedReady    (seedReady),
        .key          (key),
        .keyValid     (keyValid),
        .keyReady     (keyReady),
        .streamWord   (streamWord),
        .streamValid  (streamValid),
        .creditReturn (creditReturn)
    );

    bind keyStreamTop keyStreamTb_props keyStreamTb_props_i (
        .Clock        (Clock),
        .rst          (rst),
        .seedValid    (seedValid),
        .seedReady    (seedReady),
        .relFire      (rel.fire),
        .keyReady     (keyReady),
        .streamValid  (streamValid),
        .creditReturn (creditReturn)
    );

    always #5 Clock = ~Clock;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // XOR key, rotate left 5, add round number to low word
    function automatic blockT cipherModel(input blockT pt, input keyT k);
        blockT s;
        int    r;
        s = pt;
        for (r = 1; r <= `KS_ROUNDS; r++) begin
            s = s ^ k;
            s = {s[122:0], s[127:123]};
            s[31:0] = s[31:0] + 32'(r);
        end
        return s;
    endfunction

    // Lane j enciphers seed + j, zero-extended
    function automatic streamWordT wordModel(input seedT sd, input keyT k, input seqT sq);
        streamWordT w;
        seedT       ctr;
        for (int j = 0; j < `KS_LANES; j++) begin
            ctr = sd + seedT'(j);
            w.blocks[j] = cipherModel({64'd0, ctr}, k);
        end
        w.seq = sq;
        return w;
    endfunction

    function automatic seedT randomSeed();
        return {$random(seedVar), $random(seedVar)};
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic expectTrue(input bit cond, input string what);
        assert (cond) else begin
            $display("Error in %s: %s", curTest, what);
            errCnt++;
        end
    endtask

    task automatic checkWord();
        streamWordT exp;
        int         acc;
        if (expQ.size() == 0) begin
            $display("Error in %s: word issued with no seed outstanding", curTest);
            errCnt++;
        end else begin
            exp = expQ.pop_front();
            acc = acceptQ.pop_front();
            assert (streamWord == exp) else begin
                $display("Mismatch %s: expected %h actual %h", curTest, exp, streamWord);
                errCnt++;
            end
            if (checkLatency) begin
                assert (cycleCnt - 1 - acc == `KS_ROUNDS + 1) else begin
                    $display("Mismatch %s: latency expected %0d actual %0d", curTest,
                             `KS_ROUNDS + 1, cycleCnt - 1 - acc);
                    errCnt++;
                end
            end
        end
        // Tags count words from zero
        assert (streamWord.seq == seqT'(wordsSeen)) else begin
            $display("Mismatch %s: seq expected %0d actual %0d", curTest,
                     wordsSeen, streamWord.seq);
            errCnt++;
        end
        lastSeq = streamWord.seq;
        wordsSeen++;
        // Consumer frees the word 0 to 6 cycles later
        dueQ.push_back(cycleCnt + ($unsigned($random(seedVar)) % 7));
    endtask

    // Transfers, edge count, and the model queue
    always @(posedge Clock) begin
        if (!rst && seedValid && seedReady) begin
            expQ.push_back(wordModel(seed, modelKey, refSeq));
            acceptQ.push_back(cycleCnt);
            refSeq++;
        end
        if (!rst && keyValid && keyReady) begin
            modelKey = key;
        end
        cycleCnt++;
    end

    // Output check and credit return, both on the falling edge
    always @(negedge Clock) begin
        if (!rst && streamValid) begin
            checkWord();
        end
        creditReturn = 1'b0;
        if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycleCnt) begin
            creditReturn = 1'b1;
            void'(dueQ.pop_front());
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic loadKey(input keyT k);
        key      = k;
        keyValid = 1'b1;
        while (!keyReady) @(negedge Clock);
        @(negedge Clock);
        keyValid = 1'b0;
    endtask

    // Leaves seedValid high for back-to-back use
    task automatic sendSeed(input seedT s);
        seed      = s;
        seedValid = 1'b1;
        while (!seedReady) begin
            sawFull = 1'b1;
            @(negedge Clock);
        end
        @(negedge Clock);
    endtask

    task automatic sendSeeds(input int n);
        for (int i = 0; i < n; i++) begin
            sendSeed(randomSeed());
        end
        seedValid = 1'b0;
    endtask

    // All words out and all credits back
    task automatic drainWords();
        while (expQ.size() != 0 || dueQ.size() != 0) @(negedge Clock);
        repeat (2) @(negedge Clock);
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        errAtStart = errCnt + keyStreamTop_i.keyStreamTb_props_i.propFails;
    endtask

    task automatic finishTest();
        int errs;
        errs = errCnt + keyStreamTop_i.keyStreamTb_props_i.propFails - errAtStart;
        if (errs == 0) begin
            $display("test %s: passed", curTest);
            passTests++;
        end else begin
            $display("test %s: failed with %0d errors", curTest, errs);
            failTests++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        keyT newKey;
        int  base;
        Clock = 1'b0;
        rst = 1'b1;
        seed = '0;
        seedValid = 1'b0;
        key = '0;
        keyValid = 1'b0;
        creditReturn = 1'b0;
        seedVar = 32'h623a_683b;
        modelKey = '0;
        refSeq = '0;
        lastSeq = '0;
        cycleCnt = 0;
        wordsSeen = 0;
        errCnt = 0;
        passTests = 0;
        failTests = 0;
        holdCredits = 1'b0;
        checkLatency = 1'b0;
        sawFull = 1'b0;
        curTest = "reset";
        repeat (5) @(negedge Clock);
        rst = 1'b0;

        // 1. Idle outputs, no seeds before a key
        startTest("reset");
        expectTrue(!streamValid && !seedReady, "outputs not idle after reset");
        seedValid = 1'b1;
        seed = randomSeed();
        repeat (4) begin
            expectTrue(!seedReady, "seedReady high before a key was loaded");
            @(negedge Clock);
        end
        seedValid = 1'b0;
        loadKey({randomSeed(), randomSeed()});
        expectTrue(seedReady, "seedReady still low after the key was loaded");
        finishTest();

        // 2. Single seed, fixed latency, seq 0
        startTest("single");
        checkLatency = 1'b1;
        sendSeeds(1);
        drainWords();
        checkLatency = 1'b0;
        expectTrue(wordsSeen == 1 && lastSeq == 0, "single seed did not give word 0");
        finishTest();

        // 3. Burst past the slot count
        startTest("burst");
        base = wordsSeen;
        sawFull = 1'b0;
        sendSeeds(`KS_SLOTS + 4);
        expectTrue(sawFull, "seedReady never fell with all slots occupied");
        drainWords();
        expectTrue(wordsSeen - base == `KS_SLOTS + 4, "burst lost words");
        finishTest();

        // 4. Credits withheld, then returned
        startTest("credits");
        base = wordsSeen;
        holdCredits = 1'b1;
        sendSeeds(6);
        repeat (`KS_ROUNDS + 20) @(negedge Clock);
        expectTrue(wordsSeen - base == `KS_OUT_CREDITS, "words issued beyond held credits");
        holdCredits = 1'b0;
        drainWords();
        expectTrue(wordsSeen - base == 6, "held words never came out");
        finishTest();

        // 5. Key port closed in flight, new key once idle
        startTest("rekey");
        sendSeeds(4);
        key = {randomSeed(), randomSeed()};
        keyValid = 1'b1;
        repeat (`KS_ROUNDS - 2) begin
            expectTrue(!keyReady, "keyReady high with seeds in flight");
            @(negedge Clock);
        end
        keyValid = 1'b0;
        drainWords();
        expectTrue(keyReady, "keyReady low with the pipeline idle");
        newKey = {randomSeed(), randomSeed()};
        loadKey(newKey);
        // Counter wraps inside the word
        sendSeed(64'hFFFF_FFFF_FFFF_FFFE);
        sendSeeds(3);
        drainWords();
        finishTest();

        $display("Summary: %0d tests passed, %0d tests failed", passTests, failTests);
        if (failTests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LimitNs);
        $display("Timeout: run still going after %0d ns in test %s", LimitNs, curTest);
        $display("Test failed");
        $finish;
    end

endmodule

//--- tests/keyStreamTb_props.sv
// Protocol assertions for the keystream generator
// Bound into keyStreamTop by the testbench, failures counted in propFails
`timescale 1ns/10ps
`include "keyStream_cfg.svh"

module keyStreamTb_props (
    input logic Clock,
    input logic rst,
    input logic seedValid,
    input logic seedReady,
    input logic relFire,
    input logic keyReady,
    input logic streamValid,
    input logic creditReturn
);

    int outstanding;
    int held;
    int propFails = 0;

    // Words issued and not yet credited back
    always @(posedge Clock) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(streamValid) - int'(creditReturn);
        end
    end

    // Slots holding a seed, seed transfers minus releases
    always @(posedge Clock) begin
        if (rst) begin
            held <= 0;
        end else begin
            held <= held + int'(seedValid && seedReady) - int'(relFire);
        end
    end

    // Each valid word spends a credit that was held
    validNeedsCredit: assert property (@(posedge Clock) disable iff (rst)
        streamValid |-> (outstanding < `KS_OUT_CREDITS))
        else begin
            $error("streamValid asserted with no output credit held");
            propFails++;
        end

    // Never more words in the consumer than credits granted
    creditBound: assert property (@(posedge Clock) disable iff (rst)
        outstanding <= `KS_OUT_CREDITS)
        else begin
            $error("more words outstanding than output credits");
            propFails++;
        end

    // No seed taken with every slot occupied
    seedNeedsSlot: assert property (@(posedge Clock) disable iff (rst)
        (seedValid && seedReady) |-> (held < `KS_SLOTS))
        else begin
            $error("seed accepted while all slots were occupied");
            propFails++;
        end

    // Key port open only with an empty slot array
    keyOnlyIdle: assert property (@(posedge Clock) disable iff (rst)
        keyReady |-> (held == 0))
        else begin
            $error("keyReady high while slots were busy");
            propFails++;
        end

endmodule
